/* include/rv_decode_macros.svh */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// data and address width
`define XLEN 32

// fetch queue entries, keep it a power of two
`define QUEUE_DEPTH 4

// pc given to the first word after reset
`define RESET_PC 32'h0000_0000

`endif

/* design/rv_decode_pkg.sv */
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

  // rv32i base opcodes handled by the decoder
  typedef enum logic [6:0] {
    r_type       = 7'b0110011,
    i_type_logic = 7'b0010011,
    i_type_load  = 7'b0000011,
    i_type_jalr  = 7'b1100111,
    s_type       = 7'b0100011,
    b_type       = 7'b1100011,
    j_type       = 7'b1101111,
    u_type_auipc = 7'b0010111,
    u_type_lui   = 7'b0110111
  } opcode_t;

  // main decoder to alu decoder
  typedef enum logic [1:0] {
    alu_op_mem_access = 2'b00, // add
    alu_op_branch     = 2'b01, // subtract for compare
    alu_op_reg_op     = 2'b10, // look at funct3/funct7
    alu_op_unset      = 2'b11
  } alu_op_t;

  // encoding is {funct7[5], funct3} where it can be
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    opcode_t          opcode;
    alu_ctrl_t        alu_ctrl;
    logic [2:0]       funct3;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] target; // pc + imm for branches and jal
  } decoded_t;

endpackage

`default_nettype wire

/* design/alu_decoder.sv */
`default_nettype none

module alu_decoder (
  input  rv_decode_pkg::alu_op_t   alu_op,
  input  logic [2:0]               funct3,
  input  logic [6:0]               funct7,
  output rv_decode_pkg::alu_ctrl_t alu_ctrl
);

  import rv_decode_pkg::*;

  logic alt; // funct7[5], picks sub and sra

  assign alt = funct7[5];

  // reg_op follows funct3, the alternate bit only matters for add and srl
  always_comb begin
    case (alu_op)
      alu_op_mem_access: alu_ctrl = alu_add;
      alu_op_branch:     alu_ctrl = alu_sub; // compare by subtract
      alu_op_reg_op: begin
        case (funct3)
          3'b000:  alu_ctrl = alt ? alu_sub : alu_add;
          3'b001:  alu_ctrl = alu_sll;
          3'b010:  alu_ctrl = alu_slt;
          3'b011:  alu_ctrl = alu_sltu;
          3'b100:  alu_ctrl = alu_xor;
          3'b101:  alu_ctrl = alt ? alu_sra : alu_srl;
          3'b110:  alu_ctrl = alu_or;
          default: alu_ctrl = alu_and;
        endcase
      end
      default: alu_ctrl = alu_add; // unset
    endcase
  end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module instr_decode (
  input  logic [`XLEN-1:0]         instr,
  output rv_decode_pkg::opcode_t   opcode,
  output rv_decode_pkg::alu_ctrl_t alu_ctrl,
  output logic [`XLEN-1:0]         imm,
  output logic [2:0]               funct3,
  output logic [4:0]               rd,
  output logic [4:0]               rs1,
  output logic [4:0]               rs2
);

  import rv_decode_pkg::*;

  alu_op_t    alu_op;
  logic [6:0] funct7;
  logic       shift_imm;

  assign opcode = opcode_t'(instr[6:0]);

  // slli/srli/srai carry funct7 in the upper immediate bits
  assign shift_imm = (instr[13:12] == 2'b01);

  // funct3 and funct7 for the alu decoder
  always_comb begin
    funct3 = 3'b000;
    funct7 = 7'b0;
    case (opcode)
      r_type: begin
        funct3 = instr[14:12];
        funct7 = instr[31:25];
      end
      i_type_logic: begin
        funct3 = instr[14:12];
        if (shift_imm) funct7 = instr[31:25]; // addi etc keep funct7 zero
      end
      i_type_load, i_type_jalr, s_type, b_type: funct3 = instr[14:12];
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      r_type, i_type_logic: alu_op = alu_op_reg_op;
      i_type_load:          alu_op = alu_op_mem_access;
      i_type_jalr:          alu_op = alu_op_mem_access; // rs1 + imm
      s_type:               alu_op = alu_op_mem_access;
      b_type:               alu_op = alu_op_branch;
      u_type_auipc:         alu_op = alu_op_mem_access;
      u_type_lui:           alu_op = alu_op_mem_access; // 0 + imm
      default:              alu_op = alu_op_unset;
    endcase
  end

  // register fields by format, everything else stays zero
  always_comb begin
    rd  = 5'd0;
    rs1 = 5'd0;
    rs2 = 5'd0;
    case (opcode)
      r_type: begin
        rd  = instr[11:7];
        rs1 = instr[19:15];
        rs2 = instr[24:20];
      end
      i_type_logic, i_type_load, i_type_jalr: begin
        rd  = instr[11:7];
        rs1 = instr[19:15];
      end
      s_type, b_type: begin
        rs1 = instr[19:15];
        rs2 = instr[24:20];
      end
      j_type, u_type_auipc, u_type_lui: rd = instr[11:7];
      default: ;
    endcase
  end

  // immediate extension
  always_comb begin
    case (opcode)
      i_type_logic, i_type_load, i_type_jalr:
        imm = {{20{instr[31]}}, instr[31:20]};
      s_type:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      b_type:
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      j_type:
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      u_type_auipc, u_type_lui:
        imm = {instr[31:12], 12'b0};
      default:
        imm = '0;
    endcase
  end

  alu_decoder u_alu_decoder (
    .alu_op   (alu_op),
    .funct3   (funct3),
    .funct7   (funct7),
    .alu_ctrl (alu_ctrl)
  );

endmodule

`default_nettype wire

/* design/fetch_sequencer.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module fetch_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_strobe,
  input  logic [`XLEN-1:0]          instr,
  output logic                      push,
  output rv_decode_pkg::fetch_pkt_t push_pkt
);

  import rv_decode_pkg::*;

  logic [`XLEN-1:0] pc; // pc of the next accepted word

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= `RESET_PC;
      push <= 1'b0;
    end else begin
      push <= instr_strobe;
      if (instr_strobe) pc <= pc + `XLEN'd4;
    end
  end

  // packet payload, only meaningful while push is high
  always_ff @(posedge clk) begin
    if (instr_strobe) begin
      push_pkt.pc    <= pc;
      push_pkt.instr <= instr;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_queue.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module fetch_queue (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      push,
  input  rv_decode_pkg::fetch_pkt_t push_pkt,
  input  logic                      pop,
  output rv_decode_pkg::fetch_pkt_t head,
  output logic                      not_empty,
  output logic                      overflow
);

  import rv_decode_pkg::*;

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  fetch_pkt_t       mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             wr_en;

  assign full      = (count == (PTR_W + 1)'(`QUEUE_DEPTH));
  assign not_empty = (count != '0);
  // a full queue still takes a word when the head leaves in the same cycle
  assign wr_en     = push && (!full || pop);
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && !wr_en) overflow <= 1'b1; // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= push_pkt;
  end

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module issue_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_decode_pkg::fetch_pkt_t head,
  input  logic                      not_empty,
  output logic                      pop,
  output logic                      dec_strobe,
  output rv_decode_pkg::decoded_t   dec
);

  import rv_decode_pkg::*;

  opcode_t          opcode;
  alu_ctrl_t        alu_ctrl;
  logic [`XLEN-1:0] imm;
  logic [2:0]       funct3;
  logic [4:0]       rd;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic             is_ctrl;
  logic             stall;    // bubble after a control transfer
  decoded_t         dec_next;

  instr_decode u_instr_decode (
    .instr    (head.instr),
    .opcode   (opcode),
    .alu_ctrl (alu_ctrl),
    .imm      (imm),
    .funct3   (funct3),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2)
  );

  assign is_ctrl = (opcode == b_type) || (opcode == j_type) || (opcode == i_type_jalr);
  assign pop     = not_empty && !stall;

  always_comb begin
    dec_next.pc       = head.pc;
    dec_next.opcode   = opcode;
    dec_next.alu_ctrl = alu_ctrl;
    dec_next.funct3   = funct3;
    dec_next.rd       = rd;
    dec_next.rs1      = rs1;
    dec_next.rs2      = rs2;
    dec_next.imm      = imm;
    // jalr target needs rs1 so it is left at zero
    dec_next.target   = (opcode == b_type || opcode == j_type) ? head.pc + imm : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_strobe <= 1'b0;
      stall      <= 1'b0;
    end else begin
      dec_strobe <= pop;
      stall      <= pop && is_ctrl; // one cycle only
    end
  end

  always_ff @(posedge clk) begin
    if (pop) dec <= dec_next;
  end

endmodule

`default_nettype wire

/* design/rv_decode_top.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_strobe,
  input  logic [`XLEN-1:0]        instr,
  output logic                    dec_strobe,
  output rv_decode_pkg::decoded_t dec,
  output logic                    overflow
);

  import rv_decode_pkg::*;

  logic       push;
  fetch_pkt_t push_pkt;
  logic       pop;
  fetch_pkt_t head;
  logic       not_empty;

  fetch_sequencer u_fetch_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_strobe (instr_strobe),
    .instr        (instr),
    .push         (push),
    .push_pkt     (push_pkt)
  );

  fetch_queue u_fetch_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_pkt  (push_pkt),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .overflow  (overflow)
  );

  issue_stage u_issue_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .head       (head),
    .not_empty  (not_empty),
    .pop        (pop),
    .dec_strobe (dec_strobe),
    .dec        (dec)
  );

endmodule

`default_nettype wire

/* test/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

fetch_pkt_t       m_q[$];     // queue contents, head first
logic [`XLEN-1:0] m_pc;
logic             m_push;
fetch_pkt_t       m_pkt;
logic             m_stall;
logic             m_strobe;   // expected dec_strobe
decoded_t         m_dec;
logic             m_ovf;

function automatic alu_ctrl_t alu_by_funct3(input logic [2:0] f3, input logic alt);
  case (f3)
    3'b000:  return alt ? alu_sub : alu_add;
    3'b001:  return alu_sll;
    3'b010:  return alu_slt;
    3'b011:  return alu_sltu;
    3'b100:  return alu_xor;
    3'b101:  return alt ? alu_sra : alu_srl;
    3'b110:  return alu_or;
    default: return alu_and;
  endcase
endfunction

function automatic logic is_ctrl_word(input logic [`XLEN-1:0] w);
  return (w[6:0] == b_type) || (w[6:0] == j_type) || (w[6:0] == i_type_jalr);
endfunction

function automatic decoded_t ref_decode(input fetch_pkt_t p);
  decoded_t         d;
  logic [`XLEN-1:0] w;
  opcode_t          op;
  w = p.instr;
  op = opcode_t'(w[6:0]);
  d = '0;
  d.pc = p.pc;
  d.opcode = op;
  d.alu_ctrl = alu_add;
  case (op)
    r_type: begin
      d.funct3 = w[14:12];
      d.rd = w[11:7];
      d.rs1 = w[19:15];
      d.rs2 = w[24:20];
      d.alu_ctrl = alu_by_funct3(w[14:12], w[30]);
    end
    i_type_logic, i_type_load, i_type_jalr: begin
      d.funct3 = w[14:12];
      d.rd = w[11:7];
      d.rs1 = w[19:15];
      d.imm = {{20{w[31]}}, w[31:20]};
      // only the shift-right immediate uses bit 30
      if (op == i_type_logic) d.alu_ctrl = alu_by_funct3(w[14:12], w[14:12] == 3'b101 && w[30]);
    end
    s_type, b_type: begin
      d.funct3 = w[14:12];
      d.rs1 = w[19:15];
      d.rs2 = w[24:20];
      if (op == s_type) d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      else d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      if (op == b_type) d.alu_ctrl = alu_sub;
    end
    j_type: begin
      d.rd = w[11:7];
      d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    u_type_auipc, u_type_lui: begin
      d.rd = w[11:7];
      d.imm = {w[31:12], 12'b0};
    end
    default: ;
  endcase
  if (op == b_type || op == j_type) d.target = p.pc + d.imm;
  return d;
endfunction

task automatic model_reset();
  m_q.delete();
  m_pc = `RESET_PC;
  m_push = 1'b0;
  m_pkt = '0;
  m_stall = 1'b0;
  m_strobe = 1'b0;
  m_dec = '0;
  m_ovf = 1'b0;
endtask

// one rising edge of sequencer, queue and issue stage
task automatic model_clock(input logic strobe, input logic [`XLEN-1:0] word);
  logic       pop;
  logic       wr;
  fetch_pkt_t top;
  pop = (m_q.size() != 0) && !m_stall;
  wr = m_push && (m_q.size() < `QUEUE_DEPTH || pop);
  m_strobe = pop;
  m_stall = 1'b0;
  if (pop) begin
    top = m_q.pop_front();
    m_dec = ref_decode(top);
    m_stall = is_ctrl_word(top.instr);
  end
  if (m_push && !wr) m_ovf = 1'b1;
  if (wr) m_q.push_back(m_pkt);
  m_push = strobe;
  if (strobe) begin
    m_pkt.pc = m_pc;
    m_pkt.instr = word;
    m_pc = m_pc + `XLEN'd4;
  end
endtask

`endif

/* test/tb_rv_decode.sv */
`default_nettype none

`include "rv_decode_macros.svh"

module tb_rv_decode;

  import rv_decode_pkg::*;

  `include "decode_model.svh"

  localparam int N_RANDOM    = 200;
  localparam int N_BURSTS    = 25;
  localparam int BURST_LEN   = 5;
  localparam int N_FLOOD     = 20;
  localparam int STIM_CYCLES = 32 + N_RANDOM * 2 + N_BURSTS * BURST_LEN * 2 + N_FLOOD + 20;
  localparam int CYCLE_LIMIT = STIM_CYCLES * 2 + 100;

  logic             clk;
  logic             rst_n;
  logic             instr_strobe;
  logic [`XLEN-1:0] instr;
  logic             dec_strobe;
  decoded_t         dec;
  logic             overflow;
  logic [31:0]      seed;
  int               errors;
  int               checks;
  int               cycles;
  int               mark;
  int               lat;
  int               n_dec;     // dec_strobe pulses seen out of reset
  int               dec_base;

  rv_decode_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_strobe (instr_strobe),
    .instr        (instr),
    .dec_strobe   (dec_strobe),
    .dec          (dec),
    .overflow     (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // legal word of one opcode class, upper lcg bits only
  function automatic logic [31:0] make_word(input int cls);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    a = lcg_next();
    b = lcg_next();
    r = {a[31:16], b[31:16]};
    f3 = r[14:12];
    f7 = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
    case (cls)
      0: return {f7, r[24:15], f3, r[11:7], r_type};
      1: begin
        if (f3 == 3'b001) return {7'b0, r[24:15], f3, r[11:7], i_type_logic};
        if (f3 == 3'b101) return {r[30] ? 7'b0100000 : 7'b0, r[24:15], f3, r[11:7], i_type_logic};
        return {r[31:15], f3, r[11:7], i_type_logic};
      end
      2: begin
        f3 = (r[13:12] == 2'b11 || r[14:13] == 2'b11) ? 3'b010 : r[14:12]; // lb..lhu
        return {r[31:15], f3, r[11:7], i_type_load};
      end
      3: return {r[31:15], 3'b000, r[11:7], i_type_jalr};
      4: return {r[31:15], 1'b0, r[13] & ~r[12], r[12] & ~r[13], r[11:7], s_type};
      5: begin
        if (r[14:13] == 2'b01) f3 = {2'b00, r[12]};
        return {r[31:15], f3, r[11:7], b_type};
      end
      6: return {r[31:7], j_type};
      7: return {r[31:7], u_type_auipc};
      default: return {r[31:7], u_type_lui};
    endcase
  endfunction

  task automatic check_decoded(input decoded_t got, input decoded_t exp);
    string bad;
    bad = "";
    checks++;
    if (got.pc !== exp.pc) bad = {bad, " pc"};
    if (got.opcode !== exp.opcode) bad = {bad, " opcode"};
    if (got.alu_ctrl !== exp.alu_ctrl) bad = {bad, " alu_ctrl"};
    if (got.funct3 !== exp.funct3) bad = {bad, " funct3"};
    if (got.rd !== exp.rd) bad = {bad, " rd"};
    if (got.rs1 !== exp.rs1) bad = {bad, " rs1"};
    if (got.rs2 !== exp.rs2) bad = {bad, " rs2"};
    if (got.imm !== exp.imm) bad = {bad, " imm"};
    if (got.target !== exp.target) bad = {bad, " target"};
    if (bad != "") begin
      errors++;
      $display("mismatch at %0t: word at pc %h differs in%s", $time, exp.pc, bad);
    end
  endtask

  task automatic check_overflow(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: overflow is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic drive_word(input int cls);
    @(negedge clk);
    instr_strobe = 1'b1;
    instr = make_word(cls);
  endtask

  task automatic drive_idle();
    @(negedge clk);
    instr_strobe = 1'b0;
    instr = lcg_next(); // junk while idle
  endtask

  task automatic drain();
    drive_idle();
    while (m_q.size() != 0 || m_push || m_strobe) drive_idle();
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    instr_strobe = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - mark);
    mark = errors;
  endtask

  always @(posedge clk) begin
    if (!rst_n) model_reset();
    else model_clock(instr_strobe, instr);
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (dec_strobe !== m_strobe) begin
        errors++;
        if (m_strobe) $display("dec_strobe missing at %0t for pc %h", $time, m_dec.pc);
        else $display("unexpected dec_strobe at %0t", $time);
      end else if (dec_strobe) begin
        check_decoded(dec, m_dec);
      end
      if (dec_strobe) n_dec++;
      check_overflow(overflow, m_ovf);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    seed = 32'h7156;
    errors = 0;
    checks = 0;
    cycles = 0;
    mark = 0;
    n_dec = 0;
    dec_base = 0;
    rst_n = 1'b0;
    instr_strobe = 1'b0;
    instr = '0;
    model_reset();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // every class with random gaps
    for (int i = 0; i < N_RANDOM; i++) begin
      drive_word(i % 9);
      if (lcg_next() > 32'h8000_0000) drive_idle();
    end
    drain();
    end_test("decode");

    // isolated word, empty queue
    drive_word(0);
    lat = 0;
    do begin
      drive_idle();
      lat++;
    end while (!dec_strobe && lat < 10);
    if (lat != 3) begin
      errors++;
      $display("mismatch at %0t: latency was %0d cycles instead of 3", $time, lat);
    end
    drain();
    end_test("latency");

    // bursts heavy with branches
    dec_base = n_dec;
    for (int i = 0; i < N_BURSTS; i++) begin
      for (int j = 0; j < BURST_LEN; j++) drive_word(lcg_next() > 32'h6000_0000 ? 5 : j);
      repeat (BURST_LEN) drive_idle();
    end
    drain();
    if (m_ovf) begin
      errors++;
      $display("the queue overfilled during the burst test, so words were lost");
    end
    if (n_dec - dec_base != N_BURSTS * BURST_LEN) begin
      errors++;
      $display("mismatch at %0t: %0d words decoded out of %0d sent", $time,
               n_dec - dec_base, N_BURSTS * BURST_LEN);
    end
    end_test("bubbles");

    // branch flood overfills the queue
    for (int i = 0; i < N_FLOOD; i++) drive_word(5);
    drain();
    if (!m_ovf) begin
      errors++;
      $display("the branch flood did not overfill the queue");
    end
    check_overflow(overflow, 1'b1);
    apply_reset();
    drive_idle();
    check_overflow(overflow, 1'b0);
    end_test("overflow");

    $display("4 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_decode.f */
+incdir+include
+incdir+test
design/rv_decode_pkg.sv
design/alu_decoder.sv
design/instr_decode.sv
design/fetch_sequencer.sv
design/fetch_queue.sv
design/issue_stage.sv
design/rv_decode_top.sv
test/tb_rv_decode.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rv_decode testbench with verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_rv_decode -f rv_decode.f -o tb_rv_decode
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
